// File: aopd_apb_regs.sv
`default_nettype none

module aopd_apb_regs #(
	parameter int CNT_W = aopd_pkg::CNT_W
) (
	input  wire logic                pclk,
	input  wire aopd_pkg::aopd_rst_t rst,
	input  wire aopd_pkg::apb_req_t  apb,
	input  wire logic [CNT_W-1:0]    cnt_p,
	input  wire logic                load_busy,
	input  wire logic                alarm_rise,
	output logic      [CNT_W-1:0]    prdata,
	output logic                     irq,
	output logic                     en,
	output logic      [CNT_W-1:0]    alarm_val,
	output logic                     load_pulse,
	output logic      [CNT_W-1:0]    load_val
);

	aopd_pkg::aopd_reg_e reg_sel;

	logic             wr;
	logic             rd;
	logic             wr_ctrl;
	logic             wr_cnt;
	logic             wr_alarm;
	logic             wr_status;
	logic [CNT_W-1:0] wdata;
	logic             ctrl_en;
	logic [CNT_W-1:0] alarm_q;
	logic             alarm_flag;

	// --------------------
	// decode
	// --------------------
	assign reg_sel = aopd_pkg::aopd_reg_e'(apb.paddr);
	assign wdata   = apb.pwdata[CNT_W-1:0];

	// access phase only
	assign wr = apb.psel & apb.penable & apb.pwrite;
	assign rd = apb.psel & ~apb.pwrite;

	assign wr_ctrl   = wr && (reg_sel == aopd_pkg::REG_CTRL);
	assign wr_cnt    = wr && (reg_sel == aopd_pkg::REG_CNT);
	assign wr_alarm  = wr && (reg_sel == aopd_pkg::REG_ALARM);
	assign wr_status = wr && (reg_sel == aopd_pkg::REG_STATUS);

	// --------------------
	// retained registers
	// --------------------
	always_ff @(posedge pclk or negedge rst.por_psync_n) begin
		if (!rst.por_psync_n) begin
			ctrl_en <= 1'b0;
			alarm_q <= '0;
		end else begin
			if (wr_ctrl) begin
				ctrl_en <= wdata[0];
			end
			if (wr_alarm) begin
				alarm_q <= wdata;
			end
		end
	end

	// sticky alarm, a new rise wins over a clear in the same cycle
	always_ff @(posedge pclk or negedge rst.por_dbg_psync_n) begin
		if (!rst.por_dbg_psync_n) begin
			alarm_flag <= 1'b0;
		end else if (alarm_rise) begin
			alarm_flag <= 1'b1;
		end else if (wr_status && wdata[aopd_pkg::STAT_ALARM]) begin
			alarm_flag <= 1'b0;
		end
	end

	// load request dropped while one is still in flight
	assign load_pulse = wr_cnt & ~load_busy;
	assign load_val   = wdata;

	assign en        = ctrl_en;
	assign alarm_val = alarm_q;
	assign irq       = alarm_flag & ctrl_en;

	// --------------------
	// read mux
	// --------------------
	always_comb begin
		prdata = '0;
		if (rd) begin
			case (reg_sel)
				aopd_pkg::REG_CTRL: begin
					prdata[0] = ctrl_en;
				end
				aopd_pkg::REG_CNT: begin
					prdata = cnt_p;
				end
				aopd_pkg::REG_ALARM: begin
					prdata = alarm_q;
				end
				aopd_pkg::REG_STATUS: begin
					prdata[aopd_pkg::STAT_ALARM] = alarm_flag;
					prdata[aopd_pkg::STAT_BUSY]  = load_busy;
				end
				default: begin
					prdata = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: aopd_pkg.sv
`default_nettype none

package aopd_pkg;

	// --------------------
	// widths and defaults
	// --------------------
	parameter int CNT_W = 32;

	// slow clocks per count
	parameter int DIV = 32;

	// --------------------
	// register map
	// --------------------
	typedef enum logic [3:0] {
		REG_CTRL   = 4'h0,
		REG_CNT    = 4'h4,
		REG_ALARM  = 4'h8,
		REG_STATUS = 4'hC
	} aopd_reg_e;

	// status bit positions
	localparam int STAT_ALARM = 0;
	localparam int STAT_BUSY  = 1;

	// --------------------
	// bundles
	// --------------------
	// active-low reset levels per domain
	typedef struct packed {
		logic rtc_rstn;
		logic por_psync_n;
		logic por_dbg_psync_n;
	} aopd_rst_t;

	// apb request side, pready tied high
	typedef struct packed {
		logic             psel;
		logic             penable;
		logic             pwrite;
		logic [3:0]       paddr;
		logic [CNT_W-1:0] pwdata;
	} apb_req_t;

endpackage

`default_nettype wire

// File: aopd_rstgen.sv
`default_nettype none

module aopd_rstgen (
	input  wire logic         clk_32k,
	input  wire logic         pclk,
	input  wire logic         rtc_rstn_src,
	input  wire logic         test_mode,
	input  wire logic         test_rstn,
	input  wire logic         hw_rstn_delay,
	input  wire logic         dbg_srst_req,
	output aopd_pkg::aopd_rst_t rst
);

	logic rtc_sync1;
	logic rtc_sync2;
	logic por_sync1;
	logic por_sync2;
	logic dbg_sync1;
	logic dbg_sync2;

	logic rtc_lvl;
	logic dbg_mix_rstn;

	// --------------------
	// slow clock domain
	// --------------------
	always_ff @(posedge clk_32k or negedge rtc_rstn_src) begin
		if (!rtc_rstn_src) begin
			rtc_sync1 <= 1'b0;
			rtc_sync2 <= 1'b0;
		end else begin
			rtc_sync1 <= 1'b1;
			rtc_sync2 <= rtc_sync1;
		end
	end

	// scan reset takes over in test mode
	assign rtc_lvl = test_mode ? test_rstn : rtc_sync2;

	// --------------------
	// pclk domain
	// --------------------
	always_ff @(posedge pclk or negedge rtc_lvl) begin
		if (!rtc_lvl) begin
			por_sync1 <= 1'b0;
			por_sync2 <= 1'b0;
		end else begin
			por_sync1 <= 1'b1;
			por_sync2 <= por_sync1;
		end
	end

	// debug system reset and delayed hw reset also clear this one
	assign dbg_mix_rstn = rtc_lvl & ~dbg_srst_req & hw_rstn_delay;

	always_ff @(posedge pclk or negedge dbg_mix_rstn) begin
		if (!dbg_mix_rstn) begin
			dbg_sync1 <= 1'b0;
			dbg_sync2 <= 1'b0;
		end else begin
			dbg_sync1 <= 1'b1;
			dbg_sync2 <= dbg_sync1;
		end
	end

	assign rst.rtc_rstn        = rtc_lvl;
	assign rst.por_psync_n     = test_mode ? test_rstn : por_sync2;
	assign rst.por_dbg_psync_n = test_mode ? test_rstn : dbg_sync2;

endmodule

`default_nettype wire

// File: aopd_top.sv
`default_nettype none

module aopd_top #(
	parameter int CNT_W = aopd_pkg::CNT_W,
	parameter int DIV   = aopd_pkg::DIV
) (
	input  wire logic               pclk,
	input  wire logic               clk_32k,
	input  wire logic               rtc_rstn_src,
	input  wire logic               test_mode,
	input  wire logic               test_rstn,
	input  wire logic               hw_rstn_delay,
	input  wire logic               dbg_srst_req,
	input  wire aopd_pkg::apb_req_t apb,
	output logic      [CNT_W-1:0]   prdata,
	output logic                    irq,
	output aopd_pkg::aopd_rst_t     rst
);

	logic             en;
	logic             en_s;
	logic             load_pulse;
	logic             load_s;
	logic             load_busy;
	logic             alarm_hit;
	logic             alarm_rise;
	logic [CNT_W-1:0] load_val;
	logic [CNT_W-1:0] load_val_s;
	logic [CNT_W-1:0] alarm_val;
	logic [CNT_W-1:0] cnt_gray;
	logic [CNT_W-1:0] cnt_p;

	aopd_rstgen u_rstgen (
		.clk_32k       (clk_32k),
		.pclk          (pclk),
		.rtc_rstn_src  (rtc_rstn_src),
		.test_mode     (test_mode),
		.test_rstn     (test_rstn),
		.hw_rstn_delay (hw_rstn_delay),
		.dbg_srst_req  (dbg_srst_req),
		.rst           (rst)
	);

	rtc_counter #(
		.CNT_W (CNT_W),
		.DIV   (DIV)
	) u_counter (
		.clk_32k   (clk_32k),
		.rtc_rstn  (rst.rtc_rstn),
		.en_s      (en_s),
		.load_s    (load_s),
		.load_val  (load_val_s),
		.alarm_val (alarm_val),
		.cnt_gray  (cnt_gray),
		.alarm_hit (alarm_hit)
	);

	rtc_cdc #(
		.CNT_W (CNT_W)
	) u_cdc (
		.pclk       (pclk),
		.clk_32k    (clk_32k),
		.rst        (rst),
		.en         (en),
		.load_pulse (load_pulse),
		.load_val   (load_val),
		.cnt_gray   (cnt_gray),
		.alarm_hit  (alarm_hit),
		.en_s       (en_s),
		.load_s     (load_s),
		.load_val_s (load_val_s),
		.cnt_p      (cnt_p),
		.load_busy  (load_busy),
		.alarm_rise (alarm_rise)
	);

	aopd_apb_regs #(
		.CNT_W (CNT_W)
	) u_regs (
		.pclk       (pclk),
		.rst        (rst),
		.apb        (apb),
		.cnt_p      (cnt_p),
		.load_busy  (load_busy),
		.alarm_rise (alarm_rise),
		.prdata     (prdata),
		.irq        (irq),
		.en         (en),
		.alarm_val  (alarm_val),
		.load_pulse (load_pulse),
		.load_val   (load_val)
	);

endmodule

`default_nettype wire

// File: flist.f
aopd_pkg.sv
aopd_rstgen.sv
rtc_counter.sv
rtc_cdc.sv
aopd_apb_regs.sv
aopd_top.sv
tb_aopd.sv

// File: rtc_cdc.sv
`default_nettype none

module rtc_cdc #(
	parameter int CNT_W = aopd_pkg::CNT_W
) (
	input  wire logic                pclk,
	input  wire logic                clk_32k,
	input  wire aopd_pkg::aopd_rst_t rst,
	input  wire logic                en,
	input  wire logic                load_pulse,
	input  wire logic [CNT_W-1:0]    load_val,
	input  wire logic [CNT_W-1:0]    cnt_gray,
	input  wire logic                alarm_hit,
	output logic                     en_s,
	output logic                     load_s,
	output logic      [CNT_W-1:0]    load_val_s,
	output logic      [CNT_W-1:0]    cnt_p,
	output logic                     load_busy,
	output logic                     alarm_rise
);

	logic             req_tgl;
	logic             ack_p1;
	logic             ack_p2;
	logic             req_s1;
	logic             req_s2;
	logic             req_s3;
	logic             en_s1;
	logic             en_s2;
	logic [CNT_W-1:0] cnt_s1;
	logic [CNT_W-1:0] cnt_s2;
	logic             alm_p1;
	logic             alm_p2;
	logic             alm_p3;

	function automatic logic [CNT_W-1:0] gray2bin(input logic [CNT_W-1:0] g);
		logic [CNT_W-1:0] b;
		b[CNT_W-1] = g[CNT_W-1];
		for (int i = CNT_W - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	// --------------------
	// pclk to slow
	// --------------------
	always_ff @(posedge pclk or negedge rst.por_psync_n) begin
		if (!rst.por_psync_n) begin
			req_tgl <= 1'b0;
			ack_p1  <= 1'b0;
			ack_p2  <= 1'b0;
		end else begin
			req_tgl <= req_tgl ^ load_pulse;
			ack_p1  <= req_s3;
			ack_p2  <= ack_p1;
		end
	end

	// value held until the slow side has taken it
	always_ff @(posedge pclk) begin
		if (load_pulse) begin
			load_val_s <= load_val;
		end
	end

	assign load_busy = req_tgl ^ ack_p2;

	always_ff @(posedge clk_32k or negedge rst.rtc_rstn) begin
		if (!rst.rtc_rstn) begin
			req_s1 <= 1'b0;
			req_s2 <= 1'b0;
			req_s3 <= 1'b0;
			en_s1  <= 1'b0;
			en_s2  <= 1'b0;
		end else begin
			req_s1 <= req_tgl;
			req_s2 <= req_s1;
			req_s3 <= req_s2;
			en_s1  <= en;
			en_s2  <= en_s1;
		end
	end

	// toggle edge gives a one slow cycle load
	assign load_s = req_s2 ^ req_s3;
	assign en_s   = en_s2;

	// --------------------
	// slow to pclk
	// --------------------
	// multi-bit jump on load only, software waits for busy to drop
	always_ff @(posedge pclk or negedge rst.por_psync_n) begin
		if (!rst.por_psync_n) begin
			cnt_s1 <= '0;
			cnt_s2 <= '0;
			// start high so a hit already present at release is no rise
			alm_p1 <= 1'b1;
			alm_p2 <= 1'b1;
			alm_p3 <= 1'b1;
		end else begin
			cnt_s1 <= cnt_gray;
			cnt_s2 <= cnt_s1;
			alm_p1 <= alarm_hit;
			alm_p2 <= alm_p1;
			alm_p3 <= alm_p2;
		end
	end

	assign cnt_p      = gray2bin(cnt_s2);
	assign alarm_rise = alm_p2 & ~alm_p3;

endmodule

`default_nettype wire

// File: rtc_counter.sv
`default_nettype none

module rtc_counter #(
	parameter int CNT_W = aopd_pkg::CNT_W,
	parameter int DIV   = aopd_pkg::DIV
) (
	input  wire logic             clk_32k,
	input  wire logic             rtc_rstn,
	input  wire logic             en_s,
	input  wire logic             load_s,
	input  wire logic [CNT_W-1:0] load_val,
	input  wire logic [CNT_W-1:0] alarm_val,
	output logic      [CNT_W-1:0] cnt_gray,
	output logic                  alarm_hit
);

	localparam int PS_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [PS_W-1:0] PS_LAST = PS_W'(DIV - 1);

	logic [PS_W-1:0]  presc;
	logic [PS_W-1:0]  presc_next;
	logic [CNT_W-1:0] cnt_bin;
	logic [CNT_W-1:0] cnt_next;
	logic             tick;

	// --------------------
	// prescaler
	// --------------------
	assign tick = en_s && (presc == PS_LAST);

	always_comb begin
		presc_next = presc;
		if (load_s || !en_s) begin
			// keep phase at zero while stopped
			presc_next = '0;
		end else if (tick) begin
			presc_next = '0;
		end else begin
			presc_next = presc + 1'b1;
		end
	end

	// --------------------
	// counter
	// --------------------
	always_comb begin
		cnt_next = cnt_bin;
		if (load_s) begin
			cnt_next = load_val;
		end else if (tick) begin
			cnt_next = cnt_bin + 1'b1;
		end
	end

	always_ff @(posedge clk_32k or negedge rtc_rstn) begin
		if (!rtc_rstn) begin
			presc    <= '0;
			cnt_bin  <= '0;
			cnt_gray <= '0;
		end else begin
			presc   <= presc_next;
			cnt_bin <= cnt_next;
			// gray copy for the pclk side, one bit flips per count
			cnt_gray <= cnt_next ^ (cnt_next >> 1);
		end
	end

	// alarm value is quasi-static while armed
	assign alarm_hit = (cnt_bin == alarm_val);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# verilator build and run of tb_aopd, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps --top-module tb_aopd \
	-f flist.f -o Vtb_aopd && ./obj_dir/Vtb_aopd > sim.log 2>&1 || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

// File: tb_aopd.sv
`default_nettype none

module tb_aopd;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CNT_W = aopd_pkg::CNT_W;
	localparam int DIV   = 4;

	// pclk periods per slow clock, rounded up
	localparam int SLOW_RATIO = 7;
	localparam int COUNT_CYC  = DIV * SLOW_RATIO;

	// --------------------
	// wait bounds in pclk cycles
	// --------------------
	localparam int RST_BOUND   = 4 * SLOW_RATIO + 10;
	localparam int BUSY_BOUND  = 8 * SLOW_RATIO;
	localparam int ALARM_BOUND = 14 * COUNT_CYC + 20;
	localparam int RUN_CYC     = 2 * RST_BOUND + 12 * COUNT_CYC + 3 * BUSY_BOUND
		+ 2 * ALARM_BOUND;
	localparam int TIMEOUT_CYC = 4 * RUN_CYC + 1000;

	localparam aopd_pkg::aopd_rst_t RST_LOW      = 3'b000;
	localparam aopd_pkg::aopd_rst_t RST_HIGH     = 3'b111;
	localparam aopd_pkg::aopd_rst_t RST_DBG_ONLY = 3'b110;

	logic pclk;
	logic clk_32k;
	logic rtc_rstn_src;
	logic test_mode;
	logic test_rstn;
	logic hw_rstn_delay;
	logic dbg_srst_req;

	aopd_pkg::apb_req_t  apb;
	logic [CNT_W-1:0]    prdata;
	logic                irq;
	aopd_pkg::aopd_rst_t rst;

	integer           seed;
	int               errors;
	int               checks;
	int               cyc;
	int               slow_edges;
	int               edge_base;
	logic [CNT_W-1:0] cnt_base;

	// count reads waiting for the compare process
	logic [CNT_W-1:0] got_q[$];
	logic [CNT_W-1:0] exp_q[$];

	aopd_top #(
		.CNT_W (CNT_W),
		.DIV   (DIV)
	) dut0 (
		.pclk          (pclk),
		.clk_32k       (clk_32k),
		.rtc_rstn_src  (rtc_rstn_src),
		.test_mode     (test_mode),
		.test_rstn     (test_rstn),
		.hw_rstn_delay (hw_rstn_delay),
		.dbg_srst_req  (dbg_srst_req),
		.apb           (apb),
		.prdata        (prdata),
		.irq           (irq),
		.rst           (rst)
	);

	initial begin
		pclk    = 1'b0;
		clk_32k = 1'b0;
	end

	always #50 pclk = ~pclk;
	always #350 clk_32k = ~clk_32k;

	always @(posedge clk_32k) begin
		slow_edges <= slow_edges + 1;
	end

	always @(posedge pclk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYC) begin
			$display("timeout after %0d pclk cycles, run stopped", cyc);
			$display("Test FAILED");
			$finish;
		end
	end

	// --------------------
	// reference and compares
	// --------------------
	// one count per DIV slow edges from the start value
	function automatic logic [CNT_W-1:0] ref_count(input logic [CNT_W-1:0] start,
			input int edges);
		return start + CNT_W'(edges / DIV);
	endfunction

	task automatic check_word(input string name, input logic [CNT_W-1:0] got,
			input logic [CNT_W-1:0] exp, input int tol);
		logic [CNT_W-1:0] diff;
		diff = (got > exp) ? got - exp : exp - got;
		checks++;
		if (diff > CNT_W'(tol)) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h (+/-%0d)", name, got, exp, tol);
		end
	endtask

	task automatic check_rst(input string name, input aopd_pkg::aopd_rst_t got,
			input aopd_pkg::aopd_rst_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	always @(negedge pclk) begin
		if (got_q.size() > 0) begin
			check_word("cnt", got_q.pop_front(), exp_q.pop_front(), 2);
		end
	end

	// --------------------
	// apb access
	// --------------------
	task automatic apb_write(input aopd_pkg::aopd_reg_e addr, input logic [CNT_W-1:0] data);
		@(negedge pclk);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = 1'b1;
		apb.paddr   = addr;
		apb.pwdata  = data;
		@(negedge pclk);
		apb.penable = 1'b1;
		@(negedge pclk);
		apb = '0;
	endtask

	task automatic apb_read(input aopd_pkg::aopd_reg_e addr, output logic [CNT_W-1:0] data);
		@(negedge pclk);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = 1'b0;
		apb.paddr   = addr;
		apb.pwdata  = '0;
		@(negedge pclk);
		apb.penable = 1'b1;
		@(negedge pclk);
		data = prdata;
		apb  = '0;
	endtask

	task automatic read_count(output logic [CNT_W-1:0] data);
		apb_read(aopd_pkg::REG_CNT, data);
		got_q.push_back(data);
		exp_q.push_back(ref_count(cnt_base, slow_edges - edge_base));
	endtask

	task automatic wait_release(input int bound);
		int n;
		n = 0;
		while (rst !== RST_HIGH && n < bound) begin
			@(negedge pclk);
			n++;
		end
		checks++;
		if (rst !== RST_HIGH) begin
			errors++;
			$display("reset levels still asserted after %0d pclk cycles", bound);
		end
	endtask

	task automatic wait_irq(input int bound);
		int n;
		n = 0;
		while (irq !== 1'b1 && n < bound) begin
			@(negedge pclk);
			n++;
		end
		checks++;
		if (irq !== 1'b1) begin
			errors++;
			$display("irq did not rise within %0d pclk cycles", bound);
		end
	endtask

	task automatic finish_test(input int num, input string name, input int err_start);
		while (got_q.size() != 0) begin
			@(posedge pclk);
		end
		if (errors == err_start) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			$display("test %0d %s: FAIL with %0d errors", num, name, errors - err_start);
		end
	endtask

	// --------------------
	// tests
	// --------------------
	initial begin
		logic [CNT_W-1:0] rd;
		logic [CNT_W-1:0] prev;
		logic [CNT_W-1:0] val;
		logic [CNT_W-1:0] alarm_set;
		int               e0;
		int               n;
		int               offset;

		seed          = 78;
		errors        = 0;
		checks        = 0;
		edge_base     = 0;
		cnt_base      = '0;
		apb           = '0;
		rtc_rstn_src  = 1'b0;
		test_mode     = 1'b0;
		test_rstn     = 1'b1;
		hw_rstn_delay = 1'b1;
		dbg_srst_req  = 1'b0;

		// after reset
		e0 = errors;
		repeat (5) @(negedge pclk);
		check_rst("rst", rst, RST_LOW);
		rtc_rstn_src = 1'b1;
		wait_release(RST_BOUND);
		repeat (5) @(negedge pclk);
		apb_read(aopd_pkg::REG_CTRL, rd);
		check_word("ctrl", rd, '0, 0);
		apb_read(aopd_pkg::REG_ALARM, rd);
		check_word("alarm", rd, '0, 0);
		apb_read(aopd_pkg::REG_STATUS, rd);
		check_word("status", rd, '0, 0);
		check_bit("irq", irq, 1'b0);
		finish_test(1, "after reset", e0);

		// scan reset bypass
		e0 = errors;
		@(negedge pclk);
		test_mode = 1'b1;
		@(negedge pclk);
		check_rst("rst", rst, RST_HIGH);
		test_rstn = 1'b0;
		@(negedge pclk);
		check_rst("rst", rst, RST_LOW);
		test_rstn = 1'b1;
		@(negedge pclk);
		check_rst("rst", rst, RST_HIGH);
		test_mode = 1'b0;
		wait_release(RST_BOUND);
		finish_test(2, "test mode", e0);

		// counter was cleared by the scan reset
		e0 = errors;
		apb_write(aopd_pkg::REG_CTRL, CNT_W'(1));
		edge_base = slow_edges;
		cnt_base  = '0;
		prev      = '0;
		for (int i = 0; i < 8; i++) begin
			repeat (20) @(negedge pclk);
			read_count(rd);
			checks++;
			if (rd < prev) begin
				errors++;
				$display("ERROR cnt got 0x%h after 0x%h, count went down", rd, prev);
			end
			prev = rd;
		end
		apb_write(aopd_pkg::REG_CTRL, '0);
		repeat (40) @(negedge pclk);
		apb_read(aopd_pkg::REG_CNT, prev);
		repeat (40) @(negedge pclk);
		apb_read(aopd_pkg::REG_CNT, rd);
		check_word("cnt", rd, prev, 0);
		finish_test(3, "counting", e0);

		// load through the toggle crossing
		e0 = errors;
		apb_write(aopd_pkg::REG_CTRL, CNT_W'(1));
		val = $random(seed);
		val[CNT_W-1] = 1'b0;
		apb_write(aopd_pkg::REG_CNT, val);
		edge_base = slow_edges;
		cnt_base  = val;
		apb_read(aopd_pkg::REG_STATUS, rd);
		check_bit("status.busy", rd[1], 1'b1);
		n = 0;
		while (rd[1] && n < BUSY_BOUND) begin
			apb_read(aopd_pkg::REG_STATUS, rd);
			n++;
		end
		checks++;
		if (rd[1]) begin
			errors++;
			$display("load_busy still high after %0d status polls", n);
		end
		read_count(rd);
		finish_test(4, "load", e0);

		// alarm a few counts ahead
		e0 = errors;
		apb_write(aopd_pkg::REG_STATUS, CNT_W'(1));
		apb_read(aopd_pkg::REG_CNT, rd);
		check_bit("irq", irq, 1'b0);
		offset    = 3 + (($random(seed) & 32'h7fff_ffff) % 8);
		alarm_set = rd + CNT_W'(offset);
		apb_write(aopd_pkg::REG_ALARM, alarm_set);
		wait_irq((offset + 3) * COUNT_CYC + 20);
		apb_read(aopd_pkg::REG_STATUS, rd);
		check_bit("status.alarm", rd[0], 1'b1);
		apb_write(aopd_pkg::REG_STATUS, CNT_W'(1));
		check_bit("irq", irq, 1'b0);
		finish_test(5, "alarm", e0);

		// debug reset clears only the status side
		e0 = errors;
		apb_read(aopd_pkg::REG_CNT, rd);
		alarm_set = rd + CNT_W'(3);
		apb_write(aopd_pkg::REG_ALARM, alarm_set);
		wait_irq(6 * COUNT_CYC + 20);
		@(negedge pclk);
		dbg_srst_req = 1'b1;
		@(negedge pclk);
		check_rst("rst", rst, RST_DBG_ONLY);
		check_bit("irq", irq, 1'b0);
		dbg_srst_req = 1'b0;
		wait_release(RST_BOUND);
		apb_read(aopd_pkg::REG_STATUS, rd);
		check_bit("status.alarm", rd[0], 1'b0);
		check_bit("irq", irq, 1'b0);
		apb_read(aopd_pkg::REG_CTRL, rd);
		check_word("ctrl", rd, CNT_W'(1), 0);
		apb_read(aopd_pkg::REG_ALARM, rd);
		check_word("alarm", rd, alarm_set, 0);
		finish_test(6, "debug reset", e0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
